// File: src/drum_pkg.sv
package drum_pkg;

    // ==================================================
    // Timing, cycle counts scaled down for simulation
    // ==================================================

    // Sensor reset pin rises this many cycles after board reset release
    localparam int SENSOR_RST_HOLD = 20;
    // Controller leaves reset after the sensor has had time to boot
    localparam int CTRL_RST_DELAY  = 60;
    // System clocks per sclk half period
    localparam int SPI_CLK_DIV     = 2;
    // Cycles to wait for the sensor interrupt after the wake request
    localparam int WAKE_TIMEOUT    = 200;
    // Heartbeat LED follows this counter bit
    localparam int HEARTBEAT_BIT   = 4;

    // ==================================================
    // Sensor reports and commands
    // ==================================================

    // Fixed read length, id byte plus four 16-bit words
    localparam int READ_LEN = 9;
    localparam logic [7:0] RPT_QUAT = 8'h05;
    localparam logic [7:0] RPT_GYRO = 8'h02;

    // Report-enable command, sent MSB first one byte at a time
    localparam int CFG_LEN = 4;
    localparam logic [7:0] CFG_CMD [CFG_LEN] = '{8'hFD, 8'h05, 8'h00, 8'h00};

    // ==================================================
    // MCU packet
    // ==================================================

    localparam logic [7:0] PKT_HEADER = 8'hA5;
    localparam int PKT_LEN = 16;

    // Controller FSM states
    typedef enum logic [2:0] {
        ST_WAKE,
        ST_CFG,
        ST_IDLE,
        ST_READ,
        ST_ERROR
    } ctrl_state_t;

endpackage

// File: src/sensor_rst_seq.sv
`timescale 1ns/100ps

module sensor_rst_seq import drum_pkg::*; (
    input  logic clk,
    input  logic fpga_rst_n,
    output logic bno085_rst_n,
    output logic ctrl_rst_n,
    output logic led_heartbeat
);

    // Saturates once the controller reset is released
    logic [$clog2(CTRL_RST_DELAY+1)-1:0] rst_cnt;
    // Free-running, restarts with the controller
    logic [HEARTBEAT_BIT:0]              hb_cnt;

    // ==================================================
    // Reset sequencing after board reset release
    // ==================================================
    always_ff @(posedge clk or negedge fpga_rst_n) begin
        if (!fpga_rst_n) begin
            rst_cnt      <= '0;
            bno085_rst_n <= 1'b0;
            ctrl_rst_n   <= 1'b0;
        end else begin
            if (rst_cnt != CTRL_RST_DELAY) begin
                rst_cnt <= rst_cnt + 1'b1;
            end
            // Sensor held in reset for the first SENSOR_RST_HOLD cycles
            bno085_rst_n <= (rst_cnt >= SENSOR_RST_HOLD);
            // Controller starts once the sensor has booted
            ctrl_rst_n   <= (rst_cnt >= CTRL_RST_DELAY);
        end
    end

    // Heartbeat only runs while the controller is out of reset
    always_ff @(posedge clk or negedge ctrl_rst_n) begin
        if (!ctrl_rst_n) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    assign led_heartbeat = hb_cnt[HEARTBEAT_BIT];

endmodule

// File: src/sensor_spi_master.sv
`timescale 1ns/100ps

module sensor_spi_master import drum_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_start,
    input  logic [7:0] spi_tx_data,
    output logic       spi_busy,
    output logic       spi_rx_valid,
    output logic [7:0] spi_rx_data,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso
);

    // Divider within one sclk half period
    logic [$clog2(SPI_CLK_DIV)-1:0] div_cnt;
    // Half period index where even ones end in a falling edge
    logic [3:0]                     half_cnt;
    logic [7:0]                     tx_sh;
    logic [7:0]                     rx_sh;
    // Last system clock of a half period
    logic                           half_end;

    assign half_end = (div_cnt == SPI_CLK_DIV - 1);

    // ==================================================
    // Mode 3 byte engine
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt      <= '0;
            half_cnt     <= '0;
            tx_sh        <= 8'h00;
            rx_sh        <= 8'h00;
            spi_busy     <= 1'b0;
            spi_rx_valid <= 1'b0;
            spi_rx_data  <= 8'h00;
            sclk         <= 1'b1;
            mosi         <= 1'b0;
        end else begin
            spi_rx_valid <= 1'b0;
            if (!spi_busy) begin
                // Start strobes only count while idle
                if (spi_start) begin
                    spi_busy <= 1'b1;
                    div_cnt  <= '0;
                    half_cnt <= '0;
                    tx_sh    <= spi_tx_data;
                end
            end else if (!half_end) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt  <= '0;
                half_cnt <= half_cnt + 1'b1;
                if (!half_cnt[0]) begin
                    // Falling edge puts the next bit out
                    sclk  <= 1'b0;
                    mosi  <= tx_sh[7];
                    tx_sh <= {tx_sh[6:0], 1'b0};
                end else begin
                    // Rising edge takes the sensor bit
                    sclk  <= 1'b1;
                    rx_sh <= {rx_sh[6:0], miso};
                    // Eighth rising edge ends the byte
                    if (half_cnt == 4'd15) begin
                        spi_busy     <= 1'b0;
                        spi_rx_valid <= 1'b1;
                        spi_rx_data  <= {rx_sh[6:0], miso};
                    end
                end
            end
        end
    end

endmodule

// File: src/imu_controller.sv
`timescale 1ns/100ps

module imu_controller import drum_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    output logic               sclk,
    output logic               mosi,
    input  logic               miso,
    output logic               cs_n,
    output logic               ps0_wake,
    input  logic               int_n,
    output logic               quat_valid,
    output logic signed [15:0] quat_w,
    output logic signed [15:0] quat_x,
    output logic signed [15:0] quat_y,
    output logic signed [15:0] quat_z,
    output logic               gyro_valid,
    output logic signed [15:0] gyro_x,
    output logic signed [15:0] gyro_y,
    output logic signed [15:0] gyro_z,
    output logic               initialized,
    output logic               error
);

    ctrl_state_t state;

    // Byte interface to the SPI master
    logic       spi_start;
    logic [7:0] spi_tx_data;
    logic       spi_busy;
    logic       spi_rx_valid;
    logic [7:0] spi_rx_data;

    // Interrupt synchronizer, idles high
    logic [1:0] int_sync;
    logic       int_low;

    // Frame bookkeeping
    logic       in_flight;
    logic       frame_done;
    logic       last_byte;
    logic [3:0] byte_idx;
    logic [$clog2(WAKE_TIMEOUT)-1:0] wake_cnt;

    // Raw bytes of the current read
    logic [7:0] rx_buf [READ_LEN];

    sensor_spi_master u_sensor_spi_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .spi_start    (spi_start),
        .spi_tx_data  (spi_tx_data),
        .spi_busy     (spi_busy),
        .spi_rx_valid (spi_rx_valid),
        .spi_rx_data  (spi_rx_data),
        .sclk         (sclk),
        .mosi         (mosi),
        .miso         (miso)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_sync <= 2'b11;
        end else begin
            int_sync <= {int_sync[0], int_n};
        end
    end

    assign int_low = !int_sync[1];

    // Command frame is shorter than a report read
    assign last_byte = (state == ST_CFG) ? (byte_idx == 4'(CFG_LEN - 1))
                                         : (byte_idx == 4'(READ_LEN - 1));

    // ==================================================
    // Sequencer and frame engine
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_WAKE;
            cs_n        <= 1'b1;
            ps0_wake    <= 1'b1;
            spi_start   <= 1'b0;
            spi_tx_data <= 8'h00;
            in_flight   <= 1'b0;
            frame_done  <= 1'b0;
            byte_idx    <= '0;
            wake_cnt    <= '0;
            initialized <= 1'b0;
            error       <= 1'b0;
            quat_valid  <= 1'b0;
            gyro_valid  <= 1'b0;
        end else begin
            spi_start  <= 1'b0;
            frame_done <= 1'b0;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;

            // One byte at a time while the frame is open
            if (!cs_n) begin
                if (!in_flight && !spi_busy) begin
                    spi_start   <= 1'b1;
                    in_flight   <= 1'b1;
                    // Reads clock out zeros
                    spi_tx_data <= (state == ST_CFG) ? CFG_CMD[byte_idx[1:0]] : 8'h00;
                end else if (spi_rx_valid) begin
                    in_flight <= 1'b0;
                    if (last_byte) begin
                        cs_n       <= 1'b1;
                        frame_done <= 1'b1;
                        byte_idx   <= '0;
                    end else begin
                        byte_idx <= byte_idx + 1'b1;
                    end
                end
            end

            case (state)
                ST_WAKE: begin
                    // Sensor answers the wake request with its interrupt
                    if (int_low) begin
                        ps0_wake <= 1'b1;
                        cs_n     <= 1'b0;
                        state    <= ST_CFG;
                    end else if (wake_cnt == WAKE_TIMEOUT - 1) begin
                        ps0_wake <= 1'b1;
                        error    <= 1'b1;
                        state    <= ST_ERROR;
                    end else begin
                        ps0_wake <= 1'b0;
                        wake_cnt <= wake_cnt + 1'b1;
                    end
                end
                ST_CFG: begin
                    if (frame_done) begin
                        initialized <= 1'b1;
                        state       <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    // Interrupt stays low until the report is read
                    if (int_low) begin
                        cs_n  <= 1'b0;
                        state <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (frame_done) begin
                        quat_valid <= (rx_buf[0] == RPT_QUAT);
                        gyro_valid <= (rx_buf[0] == RPT_GYRO);
                        state      <= ST_IDLE;
                    end
                end
                default: begin
                    // Error is sticky until reset
                end
            endcase
        end
    end

    // Collect read bytes in order
    always_ff @(posedge clk) begin
        if (spi_rx_valid && state == ST_READ) begin
            rx_buf[byte_idx] <= spi_rx_data;
        end
    end

    // ==================================================
    // Report decoding, little-endian words after the id
    // ==================================================
    always_ff @(posedge clk) begin
        if (state == ST_READ && frame_done) begin
            case (rx_buf[0])
                RPT_QUAT: begin
                    quat_w <= {rx_buf[2], rx_buf[1]};
                    quat_x <= {rx_buf[4], rx_buf[3]};
                    quat_y <= {rx_buf[6], rx_buf[5]};
                    quat_z <= {rx_buf[8], rx_buf[7]};
                end
                RPT_GYRO: begin
                    // Last word of a gyro report is unused
                    gyro_x <= {rx_buf[2], rx_buf[1]};
                    gyro_y <= {rx_buf[4], rx_buf[3]};
                    gyro_z <= {rx_buf[6], rx_buf[5]};
                end
                default: begin
                    // Unknown ids are dropped
                end
            endcase
        end
    end

endmodule

// File: src/mcu_spi_slave.sv
`timescale 1ns/100ps

module mcu_spi_slave import drum_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cs_n,
    input  logic               sck,
    output logic               sdo,
    input  logic               initialized,
    input  logic               error,
    input  logic               quat_valid,
    input  logic signed [15:0] quat_w,
    input  logic signed [15:0] quat_x,
    input  logic signed [15:0] quat_y,
    input  logic signed [15:0] quat_z,
    input  logic               gyro_valid,
    input  logic signed [15:0] gyro_x,
    input  logic signed [15:0] gyro_y,
    input  logic signed [15:0] gyro_z
);

    // Two-flop synchronizers and previous values for edge detection
    logic [1:0] cs_sync;
    logic [1:0] sck_sync;
    logic       cs_s;
    logic       cs_d;
    logic       sck_d;
    logic       cs_fall;
    logic       sck_fall;

    // Updates held back while the MCU is reading
    logic       quat_pend;
    logic       gyro_pend;

    logic signed [15:0] snap_qw;
    logic signed [15:0] snap_qx;
    logic signed [15:0] snap_qy;
    logic signed [15:0] snap_qz;
    logic signed [15:0] snap_gx;
    logic signed [15:0] snap_gy;
    logic signed [15:0] snap_gz;

    // Whole packet, MSB goes out first
    logic [PKT_LEN*8-1:0] pkt_sh;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_sync  <= 2'b11;
            sck_sync <= 2'b00;
            cs_d     <= 1'b1;
            sck_d    <= 1'b0;
        end else begin
            cs_sync  <= {cs_sync[0], cs_n};
            sck_sync <= {sck_sync[0], sck};
            cs_d     <= cs_sync[1];
            sck_d    <= sck_sync[1];
        end
    end

    assign cs_s     = cs_sync[1];
    assign cs_fall  = cs_d & ~cs_s;
    assign sck_fall = sck_d & ~sck_sync[1];

    // ==================================================
    // Snapshot, frozen while chip select is low
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quat_pend <= 1'b0;
            gyro_pend <= 1'b0;
            snap_qw   <= '0;
            snap_qx   <= '0;
            snap_qy   <= '0;
            snap_qz   <= '0;
            snap_gx   <= '0;
            snap_gy   <= '0;
            snap_gz   <= '0;
        end else begin
            // Controller holds its values, so a late copy sees the newest set
            if (quat_valid || quat_pend) begin
                quat_pend <= !cs_s;
                if (cs_s) begin
                    snap_qw <= quat_w;
                    snap_qx <= quat_x;
                    snap_qy <= quat_y;
                    snap_qz <= quat_z;
                end
            end
            if (gyro_valid || gyro_pend) begin
                gyro_pend <= !cs_s;
                if (cs_s) begin
                    snap_gx <= gyro_x;
                    snap_gy <= gyro_y;
                    snap_gz <= gyro_z;
                end
            end
        end
    end

    // Load on select, shift on each falling sck, zeros fill in behind
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            pkt_sh <= {PKT_HEADER, 6'b0, error, initialized,
                       snap_qw, snap_qx, snap_qy, snap_qz,
                       snap_gx, snap_gy, snap_gz};
        end else if (!cs_s && sck_fall) begin
            pkt_sh <= {pkt_sh[PKT_LEN*8-2:0], 1'b0};
        end
    end

    // Quiet line while deselected
    assign sdo = ~cs_s & pkt_sh[PKT_LEN*8-1];

endmodule

// File: src/drum_trigger_top.sv
`timescale 1ns/100ps

module drum_trigger_top (
    input  logic clk,
    input  logic fpga_rst_n,
    // MCU port, FPGA is the slave
    input  logic mcu_sck,
    input  logic mcu_cs_n,
    output logic mcu_sdo,
    // Orientation sensor bus
    output logic sclk,
    output logic mosi,
    input  logic miso1,
    output logic cs_n1,
    output logic ps0_wake1,
    input  logic int1,
    output logic bno085_rst_n,
    // Status LEDs
    output logic led_initialized,
    output logic led_error,
    output logic led_heartbeat
);

    logic               ctrl_rst_n;
    logic               quat_valid;
    logic signed [15:0] quat_w;
    logic signed [15:0] quat_x;
    logic signed [15:0] quat_y;
    logic signed [15:0] quat_z;
    logic               gyro_valid;
    logic signed [15:0] gyro_x;
    logic signed [15:0] gyro_y;
    logic signed [15:0] gyro_z;
    logic               initialized;
    logic               error;

    sensor_rst_seq u_sensor_rst_seq (
        .clk           (clk),
        .fpga_rst_n    (fpga_rst_n),
        .bno085_rst_n  (bno085_rst_n),
        .ctrl_rst_n    (ctrl_rst_n),
        .led_heartbeat (led_heartbeat)
    );

    // ==================================================
    // Sensor side
    // ==================================================
    imu_controller u_imu_controller (
        .clk         (clk),
        .rst_n       (ctrl_rst_n),
        .sclk        (sclk),
        .mosi        (mosi),
        .miso        (miso1),
        .cs_n        (cs_n1),
        .ps0_wake    (ps0_wake1),
        .int_n       (int1),
        .quat_valid  (quat_valid),
        .quat_w      (quat_w),
        .quat_x      (quat_x),
        .quat_y      (quat_y),
        .quat_z      (quat_z),
        .gyro_valid  (gyro_valid),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z),
        .initialized (initialized),
        .error       (error)
    );

    assign led_initialized = initialized;
    assign led_error       = error;

    // ==================================================
    // MCU side, live during the sensor boot delay
    // ==================================================
    mcu_spi_slave u_mcu_spi_slave (
        .clk         (clk),
        .rst_n       (fpga_rst_n),
        .cs_n        (mcu_cs_n),
        .sck         (mcu_sck),
        .sdo         (mcu_sdo),
        .initialized (initialized),
        .error       (error),
        .quat_valid  (quat_valid),
        .quat_w      (quat_w),
        .quat_x      (quat_x),
        .quat_y      (quat_y),
        .quat_z      (quat_z),
        .gyro_valid  (gyro_valid),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z)
    );

endmodule

// File: bench/sensor_model.sv
`timescale 1ns/100ps

module sensor_model import drum_pkg::*; (
    input  logic clk,
    input  logic silent,
    input  logic sclk,
    input  logic mosi,
    output logic miso,
    input  logic cs_n,
    input  logic ps0_wake,
    output logic int_n
);

    // Report for the next read frame, id byte on top
    logic [READ_LEN*8-1:0] report;
    // Command bytes seen in the frame after the wake answer
    logic [7:0] cmd_bytes [8];
    int         cmd_cnt;
    logic       cmd_pending;
    logic       cmd_frame;
    logic [7:0] rx_byte;
    int         bit_cnt;
    int         byte_cnt;

    initial begin
        miso        = 1'b0;
        int_n       = 1'b1;
        report      = '0;
        cmd_cnt     = 0;
        cmd_pending = 1'b0;
        cmd_frame   = 1'b0;
        rx_byte     = 8'h00;
        bit_cnt     = 0;
        byte_cnt    = 0;
    end

    // ==================================================
    // Wake answer and interrupt release
    // ==================================================
    always @(negedge ps0_wake) begin
        if (!silent) begin
            // Sensor needs a few cycles before it answers
            repeat (8) @(posedge clk);
            #1;
            cmd_pending = 1'b1;
            int_n       = 1'b0;
        end
    end

    // Interrupt is served once the host opens a frame
    always @(negedge cs_n) begin
        cmd_frame   = cmd_pending;
        cmd_pending = 1'b0;
        bit_cnt     = 0;
        byte_cnt    = 0;
        #1;
        int_n = 1'b1;
    end

    // ==================================================
    // Mode 3 shifting
    // ==================================================

    // Next bit goes out on the falling sclk edge
    always @(negedge sclk) begin
        if (!cs_n && byte_cnt < READ_LEN) begin
            #1;
            miso = report[(READ_LEN - 1 - byte_cnt) * 8 + 7 - bit_cnt];
        end
    end

    // Host data is taken on the rising edge, MSB first
    always @(posedge sclk) begin
        if (!cs_n) begin
            rx_byte = {rx_byte[6:0], mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
                if (cmd_frame && cmd_cnt < 8) begin
                    cmd_bytes[cmd_cnt] = rx_byte;
                    cmd_cnt            = cmd_cnt + 1;
                end
                bit_cnt  = 0;
                byte_cnt = byte_cnt + 1;
            end
        end
    end

    // Queue one report and raise the interrupt
    task automatic serve_report(input logic [READ_LEN*8-1:0] bytes);
        report = bytes;
        @(posedge clk);
        #1;
        int_n = 1'b0;
    endtask

endmodule

// File: bench/drum_assertions.sv
`timescale 1ns/100ps

module drum_assertions (
    input logic clk,
    input logic rst_n,
    input logic cs_n,
    input logic ps0_wake,
    input logic spi_start,
    input logic spi_busy,
    input logic initialized,
    input logic error
);

    // Failed property count
    int fail_cnt = 0;

    // No sensor frame while the wake request is active
    wake_no_frame: assert property (@(posedge clk) disable iff (!rst_n)
        !ps0_wake |-> cs_n)
        else begin
            $error("cs_n low while ps0_wake is low");
            fail_cnt = fail_cnt + 1;
        end

    // One byte at a time on the SPI master
    start_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(spi_start && spi_busy))
        else begin
            $error("spi_start while spi_busy");
            fail_cnt = fail_cnt + 1;
        end

    // Status levels exclude each other
    status_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(initialized && error))
        else begin
            $error("initialized and error both high");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind imu_controller drum_assertions u_drum_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .cs_n        (cs_n),
    .ps0_wake    (ps0_wake),
    .spi_start   (spi_start),
    .spi_busy    (spi_busy),
    .initialized (initialized),
    .error       (error)
);

// File: bench/tb_drum_trigger.sv
`timescale 1ns/100ps

module tb_drum_trigger import drum_pkg::*; ();

    logic clk;
    logic fpga_rst_n;
    logic mcu_sck;
    logic mcu_cs_n;
    logic mcu_sdo;
    logic sclk;
    logic mosi;
    logic miso1;
    logic cs_n1;
    logic ps0_wake1;
    logic int1;
    logic bno085_rst_n;
    logic led_initialized;
    logic led_error;
    logic led_heartbeat;
    logic sensor_silent;

    integer seed;

    // Expected packet contents
    logic [7:0]  exp_status;
    logic [15:0] exp_qw;
    logic [15:0] exp_qx;
    logic [15:0] exp_qy;
    logic [15:0] exp_qz;
    logic [15:0] exp_gx;
    logic [15:0] exp_gy;
    logic [15:0] exp_gz;

    drum_trigger_top u_drum_trigger_top (
        .clk             (clk),
        .fpga_rst_n      (fpga_rst_n),
        .mcu_sck         (mcu_sck),
        .mcu_cs_n        (mcu_cs_n),
        .mcu_sdo         (mcu_sdo),
        .sclk            (sclk),
        .mosi            (mosi),
        .miso1           (miso1),
        .cs_n1           (cs_n1),
        .ps0_wake1       (ps0_wake1),
        .int1            (int1),
        .bno085_rst_n    (bno085_rst_n),
        .led_initialized (led_initialized),
        .led_error       (led_error),
        .led_heartbeat   (led_heartbeat)
    );

    sensor_model u_sensor_model (
        .clk      (clk),
        .silent   (sensor_silent),
        .sclk     (sclk),
        .mosi     (mosi),
        .miso     (miso1),
        .cs_n     (cs_n1),
        .ps0_wake (ps0_wake1),
        .int_n    (int1)
    );

    always #5 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================

    // All driving and sampling happens 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string why);
        $display("%0t: %s", $time, why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Id byte followed by four little-endian words
    function automatic logic [READ_LEN*8-1:0] make_report(input logic [7:0] id,
            input logic [15:0] w0, input logic [15:0] w1,
            input logic [15:0] w2, input logic [15:0] w3);
        return {id, w0[7:0], w0[15:8], w1[7:0], w1[15:8],
                w2[7:0], w2[15:8], w3[7:0], w3[15:8]};
    endfunction

    // Header and status followed by big-endian quat and gyro words
    function automatic logic [PKT_LEN*8-1:0] expected_packet();
        return {PKT_HEADER, exp_status, exp_qw, exp_qx, exp_qy, exp_qz,
                exp_gx, exp_gy, exp_gz};
    endfunction

    task automatic apply_reset();
        fpga_rst_n = 1'b0;
        repeat (5) next_cycle();
        fpga_rst_n = 1'b1;
    endtask

    // Mode 0 read at clk/16 with a half period of 8 clocks
    task automatic mcu_read_packet(output logic [PKT_LEN*8-1:0] data);
        data = '0;
        next_cycle();
        mcu_cs_n = 1'b0;
        // Chip select passes the synchronizer and loads the packet
        repeat (8) next_cycle();
        for (int b = 0; b < PKT_LEN * 8; b++) begin
            data    = {data[PKT_LEN*8-2:0], mcu_sdo};
            mcu_sck = 1'b1;
            repeat (8) next_cycle();
            mcu_sck = 1'b0;
            repeat (8) next_cycle();
        end
        mcu_cs_n = 1'b1;
        repeat (8) next_cycle();
        check_value("mcu_sdo", mcu_sdo, 0);
    endtask

    task automatic check_packet();
        logic [PKT_LEN*8-1:0] got;
        logic [PKT_LEN*8-1:0] exp;
        mcu_read_packet(got);
        exp = expected_packet();
        for (int i = 0; i < PKT_LEN; i++) begin
            check_value($sformatf("mcu packet byte %0d", i),
                        got[(PKT_LEN-1-i)*8 +: 8], exp[(PKT_LEN-1-i)*8 +: 8]);
        end
    endtask

    // Waits out a whole sensor frame and the valid pulse and snapshot after it
    task automatic wait_sensor_frame();
        int n;
        n = 0;
        while (cs_n1 && n < 100) begin
            next_cycle();
            n++;
        end
        if (cs_n1) abort_run("sensor read frame never started");
        n = 0;
        while (!cs_n1 && n < 1000) begin
            next_cycle();
            n++;
        end
        if (!cs_n1) abort_run("sensor read frame never ended");
        repeat (8) next_cycle();
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic test_reset_outputs();
        for (int c = 0; c < SENSOR_RST_HOLD; c++) begin
            next_cycle();
            check_value("bno085_rst_n", bno085_rst_n, 0);
            check_value("led_initialized", led_initialized, 0);
            check_value("led_error", led_error, 0);
            // Sensor bus and MCU line stay idle while the controller waits
            check_value("cs_n1", cs_n1, 1);
            check_value("ps0_wake1", ps0_wake1, 1);
            check_value("sclk", sclk, 1);
            check_value("mosi", mosi, 0);
            check_value("led_heartbeat", led_heartbeat, 0);
            check_value("mcu_sdo", mcu_sdo, 0);
        end
        next_cycle();
        check_value("bno085_rst_n", bno085_rst_n, 1);
        // Packet is taken before the controller leaves reset
        exp_status = 8'h00;
        check_packet();
    endtask

    task automatic test_bring_up();
        int  n;
        logic hb;
        n = 0;
        while (!led_initialized && n < CTRL_RST_DELAY + WAKE_TIMEOUT + 100) begin
            next_cycle();
            n++;
        end
        if (!led_initialized) abort_run("led_initialized never rose");
        check_value("led_error", led_error, 0);
        check_value("command byte count", u_sensor_model.cmd_cnt, CFG_LEN);
        for (int i = 0; i < CFG_LEN; i++) begin
            check_value($sformatf("command byte %0d", i),
                        u_sensor_model.cmd_bytes[i], CFG_CMD[i]);
        end
        hb = led_heartbeat;
        n  = 0;
        while (led_heartbeat == hb && n < (1 << (HEARTBEAT_BIT + 1))) begin
            next_cycle();
            n++;
        end
        if (led_heartbeat == hb) abort_run("led_heartbeat did not toggle");
    endtask

    task automatic test_quat_report();
        exp_qw     = 16'($random(seed));
        exp_qx     = 16'($random(seed));
        exp_qy     = 16'($random(seed));
        exp_qz     = 16'($random(seed));
        exp_status = 8'h01;
        u_sensor_model.serve_report(make_report(RPT_QUAT, exp_qw, exp_qx, exp_qy, exp_qz));
        wait_sensor_frame();
        check_packet();
    endtask

    task automatic test_gyro_and_unknown();
        logic [15:0] spare;
        exp_gx = 16'($random(seed));
        exp_gy = 16'($random(seed));
        exp_gz = 16'($random(seed));
        spare  = 16'($random(seed));
        u_sensor_model.serve_report(make_report(RPT_GYRO, exp_gx, exp_gy, exp_gz, spare));
        wait_sensor_frame();
        check_packet();
        // Unknown id leaves every byte as it was
        u_sensor_model.serve_report(make_report(8'h77, 16'($random(seed)),
            16'($random(seed)), 16'($random(seed)), 16'($random(seed))));
        wait_sensor_frame();
        check_packet();
    endtask

    task automatic test_wake_timeout();
        int n;
        sensor_silent = 1'b1;
        apply_reset();
        exp_status = 8'h02;
        exp_qw     = '0;
        exp_qx     = '0;
        exp_qy     = '0;
        exp_qz     = '0;
        exp_gx     = '0;
        exp_gy     = '0;
        exp_gz     = '0;
        n = 0;
        while (!led_error && n < CTRL_RST_DELAY + WAKE_TIMEOUT + 50) begin
            next_cycle();
            check_value("led_initialized", led_initialized, 0);
            n++;
        end
        if (!led_error) abort_run("led_error did not rise after the wake timeout");
        check_value("led_initialized", led_initialized, 0);
        check_packet();
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        clk           = 1'b0;
        fpga_rst_n    = 1'b0;
        mcu_sck       = 1'b0;
        mcu_cs_n      = 1'b1;
        sensor_silent = 1'b0;
        seed          = 7;
        exp_status    = 8'h00;
        exp_qw        = '0;
        exp_qx        = '0;
        exp_qy        = '0;
        exp_qz        = '0;
        exp_gx        = '0;
        exp_gy        = '0;
        exp_gz        = '0;

        apply_reset();
        test_reset_outputs();
        test_bring_up();
        test_quat_report();
        test_gyro_and_unknown();
        test_wake_timeout();

        if (u_drum_trigger_top.u_imu_controller.u_drum_assertions.fail_cnt == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("protocol assertions failed during the run");
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: tb.f
src/drum_pkg.sv
src/sensor_rst_seq.sv
src/sensor_spi_master.sv
src/imu_controller.sv
src/mcu_spi_slave.sv
src/drum_trigger_top.sv
bench/sensor_model.sv
bench/drum_assertions.sv
bench/tb_drum_trigger.sv

// File: Bender.yml
package:
  name: drum_trigger

sources:
  - files:
      - src/drum_pkg.sv
      - src/sensor_rst_seq.sv
      - src/sensor_spi_master.sv
      - src/imu_controller.sv
      - src/mcu_spi_slave.sv
      - src/drum_trigger_top.sv
  - target: simulation
    files:
      - bench/sensor_model.sv
      - bench/drum_assertions.sv
      - bench/tb_drum_trigger.sv
